// File: common/line_flush_config.svh
`ifndef LINE_FLUSH_CONFIG_SVH
`define LINE_FLUSH_CONFIG_SVH

// geometry of one cache line as the flush engine sees it.
`define LF_WORD_WIDTH 32
`define LF_WORDS_PER_LINE 128

// the cache address is the page number above the word index.
`define LF_PAGE_BITS 2
`define LF_INDEX_BITS 7

`endif

// File: common/line_flush_pkg.sv
`default_nettype none

`include "line_flush_config.svh"

package line_flush_pkg;

    // one cache word.
    typedef logic [`LF_WORD_WIDTH-1:0] word_t;

    // the whole line buffer, word k sits at bits 32k+31 down to 32k.
    typedef logic [`LF_WORD_WIDTH*`LF_WORDS_PER_LINE-1:0] line_t;

    typedef logic [`LF_PAGE_BITS-1:0] page_t;
    typedef logic [`LF_INDEX_BITS-1:0] word_idx_t;

    // page in the upper bits, word index in the lower bits.
    typedef logic [`LF_PAGE_BITS+`LF_INDEX_BITS-1:0] cache_addr_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        LOAD  = 2'd1, // address and data are captured for the current word.
        WRITE = 2'd2, // the captured word is presented to the cache.
        DONE  = 2'd3
    } flush_state_e;

    // one write command to the cache RAM, taken on every cycle with we high.
    typedef struct packed {
        logic        we;
        cache_addr_t addr;
        word_t       data;
    } cache_wr_t;

endpackage

`default_nettype wire

// File: line_flush/line_flush_fsm.sv
`default_nettype none

module line_flush_fsm (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic last,
    output logic load,
    output logic write,
    output logic done,
    output logic busy
);
    import line_flush_pkg::*;

    flush_state_e state;
    flush_state_e next_state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // each word costs two cycles, one load followed by one write.
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start) begin // start is only looked at here.
                    next_state = LOAD;
                end
            end
            LOAD: begin
                next_state = WRITE;
            end
            WRITE: begin
                if (last) begin
                    next_state = DONE; // the final word has just been written.
                end else begin
                    next_state = LOAD;
                end
            end
            DONE: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // outputs are a plain decode of the current state.
    always_comb begin
        load  = 1'b0;
        write = 1'b0;
        done  = 1'b0;
        busy  = 1'b1;
        case (state)
            IDLE: begin
                busy = 1'b0;
            end
            LOAD: begin
                load = 1'b1;
            end
            WRITE: begin
                write = 1'b1;
            end
            DONE: begin
                done = 1'b1; // end-of-flush strobe, one cycle long.
            end
            default: begin
                busy = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: line_flush/word_counter.sv
`default_nettype none

`include "line_flush_config.svh"

module word_counter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      write,
    output line_flush_pkg::word_idx_t index,
    output logic                      last
);
    import line_flush_pkg::*;

    localparam word_idx_t LAST_INDEX = word_idx_t'(`LF_WORDS_PER_LINE - 1);

    // the index moves on at the end of every write cycle, so the next
    // load step already sees the following word.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            index <= '0;
        end else if (write) begin
            index <= index + word_idx_t'(1); // wraps to zero by the time DONE is reached.
        end
    end

    assign last = (index == LAST_INDEX);

endmodule

`default_nettype wire

// File: line_flush/word_select.sv
`default_nettype none

`include "line_flush_config.svh"

module word_select (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        load,
    input  line_flush_pkg::word_idx_t   index,
    input  line_flush_pkg::page_t       page,
    input  line_flush_pkg::line_t       line,
    output line_flush_pkg::cache_addr_t addr,
    output line_flush_pkg::word_t       data
);
    import line_flush_pkg::*;

    word_t       selected;
    cache_addr_t next_addr;

    // one indexed part select picks word k out of the line buffer.
    assign selected  = line[index*`LF_WORD_WIDTH +: `LF_WORD_WIDTH];
    assign next_addr = {page, index};

    // address and data are both captured at the end of the load cycle
    // and stay put through the write cycle that follows.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            addr <= '0;
            data <= '0;
        end else if (load) begin
            addr <= next_addr;
            data <= selected;
        end
    end

endmodule

`default_nettype wire

// File: line_flush/line_flush.sv
`default_nettype none

module line_flush (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  line_flush_pkg::line_t     line,
    input  line_flush_pkg::page_t     page,
    output line_flush_pkg::cache_wr_t cache_wr,
    output logic                      busy,
    output logic                      done
);
    import line_flush_pkg::*;

    logic        load;
    logic        write;
    logic        last;
    word_idx_t   index;
    cache_addr_t wr_addr;
    word_t       wr_data;

    line_flush_fsm u_fsm (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .last  (last),
        .load  (load),
        .write (write),
        .done  (done),
        .busy  (busy)
    );

    word_counter u_counter (
        .clk   (clk),
        .reset (reset),
        .write (write),
        .index (index),
        .last  (last)
    );

    // line and page are read straight from the inputs while busy is high.
    word_select u_select (
        .clk   (clk),
        .reset (reset),
        .load  (load),
        .index (index),
        .page  (page),
        .line  (line),
        .addr  (wr_addr),
        .data  (wr_data)
    );

    assign cache_wr = '{we: write, addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

// File: verification/line_flush_chk.sv
`default_nettype none

`include "line_flush_config.svh"

module line_flush_chk (
    input logic                      clk,
    input logic                      reset,
    input line_flush_pkg::cache_wr_t cache_wr,
    input line_flush_pkg::page_t     page,
    input logic                      busy,
    input logic                      done
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0; // read by the testbench at the end of the run.

    a_we_busy: assert property (@(posedge clk) disable iff (reset)
        cache_wr.we |-> busy)
        else begin
            failures++;
            $error("write enable is high while the engine is not busy");
        end

    // done is a strobe, so it never stays up into a second cycle.
    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else begin
            failures++;
            $error("done stayed high for more than one cycle");
        end

    a_done_no_write: assert property (@(posedge clk) disable iff (reset)
        !(done && cache_wr.we))
        else begin
            failures++;
            $error("done and write enable are high in the same cycle");
        end

    a_page_addr: assert property (@(posedge clk) disable iff (reset)
        cache_wr.we |->
            (cache_wr.addr[`LF_PAGE_BITS+`LF_INDEX_BITS-1 -: `LF_PAGE_BITS] == page))
        else begin
            failures++;
            $error("upper cache address bits differ from the page input");
        end

endmodule

bind line_flush line_flush_chk u_chk (
    .clk      (clk),
    .reset    (reset),
    .cache_wr (cache_wr),
    .page     (page),
    .busy     (busy),
    .done     (done)
);

`default_nettype wire

// File: verification/line_flush_tb.sv
`default_nettype none

`include "line_flush_config.svh"

module line_flush_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import line_flush_pkg::*;

    localparam int NUM_FLUSHES    = 7;
    localparam int FLUSH_CYCLES   = 2 * `LF_WORDS_PER_LINE + 4;
    localparam int TIMEOUT_CYCLES = NUM_FLUSHES * FLUSH_CYCLES + 100;
    localparam int DONE_CYCLE     = 2 * `LF_WORDS_PER_LINE; // counted from the start edge.

    logic      clk;
    logic      reset;
    logic      start;
    line_t     line;
    page_t     page;
    cache_wr_t cache_wr;
    logic      busy;
    logic      done;

    int unsigned rng_state;
    int          errors;
    int          tests_passed;
    int          tests_failed;

    // the monitor leaves a summary of the most recent flush here.
    int flush_count;
    int flush_writes;
    int done_cycle;
    int done_cycles;
    int last_write_cycle;
    int busy_fall_cycle;

    line_flush u_dut (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .line     (line),
        .page     (page),
        .cache_wr (cache_wr),
        .busy     (busy),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic page_t random_page();
        return page_t'(next_random() >> 30); // upper bits of an LCG are the least regular.
    endfunction

    function automatic line_t random_line();
        line_t l;
        int    k;
        for (k = 0; k < `LF_WORDS_PER_LINE; k++) begin
            l[k*`LF_WORD_WIDTH +: `LF_WORD_WIDTH] = next_random();
        end
        return l;
    endfunction

    // word k of a flush lands at {page, k} and carries bits 32k+31 down to 32k.
    function automatic cache_wr_t expected_write(line_t l, page_t p, int k);
        cache_wr_t w;
        w.we   = 1'b1;
        w.addr = {p, word_idx_t'(k)};
        w.data = l[k*`LF_WORD_WIDTH +: `LF_WORD_WIDTH];
        return w;
    endfunction

    task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
        $display("[FAIL] %s at %0t: expected 0x%0h, got 0x%0h", name, $time, expected, actual);
        errors++;
    endtask

    task automatic report_problem(string msg);
        $display("[ERROR] %s at %0t", msg, $time);
        errors++;
    endtask

    task automatic finish_test(string name, int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    // starts one flush and returns two idle cycles after done.
    task automatic run_flush(line_t l, page_t p, bit noisy_start);
        int n;
        line  = l;
        page  = p;
        start = 1'b1;
        n     = 0;
        @(negedge clk);
        if (busy !== 1'b1) begin
            report_problem("busy did not rise at the edge that sampled start");
        end
        while (!done) begin
            start = noisy_start && (n < 20 || (n % 40 == 0 && n < 240));
            n++;
            @(negedge clk);
        end
        start = 1'b0;
        repeat (2) @(negedge clk);
        if (flush_writes != `LF_WORDS_PER_LINE) begin
            report_mismatch("write count", `LF_WORDS_PER_LINE, flush_writes);
        end
    endtask

    initial begin : compare_writes
        int        cyc;
        bit        in_flush;
        line_t     flush_line;
        page_t     flush_page;
        cache_wr_t exp;
        logic      exp_we;
        flush_count  = 0;
        flush_writes = 0;
        in_flush     = 1'b0;
        cyc          = 0;
        forever begin
            @(negedge clk); // outputs only move on the rising edge.
            if (reset) begin
                if (cache_wr.we || busy || done) begin
                    report_problem("we, busy or done is high during reset");
                end
            end else if (!in_flush) begin
                if (cache_wr.we || done) begin
                    report_problem("a write or done appeared outside of a flush");
                end
                if (busy) begin
                    in_flush         = 1'b1;
                    cyc              = 0;
                    flush_line       = line;
                    flush_page       = page;
                    flush_writes     = 0;
                    done_cycle       = -1;
                    done_cycles      = 0;
                    last_write_cycle = -1;
                    busy_fall_cycle  = -1;
                end
            end
            if (in_flush) begin
                exp_we = (cyc % 2 == 1) && (cyc < DONE_CYCLE);
                if (cache_wr.we !== exp_we) begin
                    report_mismatch("cache_wr.we", exp_we, cache_wr.we);
                end
                if (done !== (cyc == DONE_CYCLE)) begin
                    report_mismatch("done", cyc == DONE_CYCLE, done);
                end
                if (busy !== (cyc <= DONE_CYCLE)) begin
                    report_mismatch("busy", cyc <= DONE_CYCLE, busy);
                end
                if (cache_wr.we) begin
                    exp = expected_write(flush_line, flush_page, flush_writes);
                    if (cache_wr.addr !== exp.addr) begin
                        report_mismatch("cache_wr.addr", exp.addr, cache_wr.addr);
                    end
                    if (cache_wr.data !== exp.data) begin
                        report_mismatch("cache_wr.data", exp.data, cache_wr.data);
                    end
                    flush_writes++;
                    last_write_cycle = cyc;
                end
                if (done) begin
                    done_cycles++;
                    if (done_cycle < 0) begin
                        done_cycle = cyc;
                    end
                end
                if (!busy || cyc == DONE_CYCLE + 1) begin
                    busy_fall_cycle = busy ? -1 : cyc;
                    in_flush        = 1'b0;
                    flush_count++;
                end
                cyc++;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin : run_tests
        int errors_before;
        int count_before;
        int p;
        rng_state    = 83;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        reset        = 1'b1;
        start        = 1'b0;
        line         = '0;
        page         = '0;
        errors_before = 0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        repeat (5) @(negedge clk);
        if (busy || flush_count != 0) begin
            report_problem("the engine started without a start request");
        end
        finish_test("reset and idle", errors_before);

        errors_before = errors;
        run_flush(random_line(), random_page(), 1'b0);
        finish_test("single flush", errors_before);

        errors_before = errors;
        run_flush(random_line(), random_page(), 1'b0);
        if (done_cycle !== last_write_cycle + 1) begin
            report_mismatch("done cycle", last_write_cycle + 1, done_cycle);
        end
        if (done_cycles !== 1) begin
            report_mismatch("done length", 1, done_cycles);
        end
        if (busy_fall_cycle !== done_cycle + 1) begin
            report_mismatch("busy fall cycle", done_cycle + 1, busy_fall_cycle);
        end
        finish_test("done and busy timing", errors_before);

        errors_before = errors;
        count_before  = flush_count;
        run_flush(random_line(), random_page(), 1'b1);
        repeat (10) @(negedge clk);
        if (busy || flush_count != count_before + 1) begin
            report_problem("a start request while busy led to another flush");
        end
        finish_test("start while busy", errors_before);

        errors_before = errors;
        for (p = 0; p < 4; p++) begin
            run_flush(random_line(), page_t'(p), 1'b0);
        end
        finish_test("back to back pages", errors_before);

        $display("tests ok: %0d, tests with errors: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, u_dut.u_chk.failures);
        if (errors == 0 && tests_failed == 0 && u_dut.u_chk.failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: line_flush.f
+incdir+common
common/line_flush_pkg.sv
line_flush/line_flush_fsm.sv
line_flush/word_counter.sv
line_flush/word_select.sv
line_flush/line_flush.sv
verification/line_flush_chk.sv
verification/line_flush_tb.sv

// File: Bender.yml
package:
  name: line_flush

sources:
  - include_dirs:
      - common
    files:
      - common/line_flush_pkg.sv
      - line_flush/line_flush_fsm.sv
      - line_flush/word_counter.sv
      - line_flush/word_select.sv
      - line_flush/line_flush.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/line_flush_chk.sv
      - verification/line_flush_tb.sv
